/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_decode
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all compile run check clean

all: check

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)

check: run
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+source
source/mips_pkg.sv
source/fetch_if.sv
source/fetch_unit.sv
source/instr_fifo.sv
source/main_decoder.sv
source/alu_decoder.sv
source/decode_stage.sv
source/mips_decode_top.sv
tb/tb_mips_decode.sv

/* source/alu_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_decoder (
	input var mips_pkg::alu_op_e  alu_op,
	input var mips_pkg::funct_e   funct,
	output mips_pkg::alu_ctrl_e   alu_ctrl
);
	always_comb begin
		case (alu_op)
			mips_pkg::ALUOP_ADD:  alu_ctrl = mips_pkg::ALU_ADD;
			mips_pkg::ALUOP_SUB:  alu_ctrl = mips_pkg::ALU_SUB;
			mips_pkg::ALUOP_AND:  alu_ctrl = mips_pkg::ALU_AND;
			mips_pkg::ALUOP_OR:   alu_ctrl = mips_pkg::ALU_OR;
			mips_pkg::ALUOP_XOR:  alu_ctrl = mips_pkg::ALU_XOR;
			mips_pkg::ALUOP_SLT:  alu_ctrl = mips_pkg::ALU_SLT;
			mips_pkg::ALUOP_SLTU: alu_ctrl = mips_pkg::ALU_SLTU;
			mips_pkg::ALUOP_LUI:  alu_ctrl = mips_pkg::ALU_LUI;
			////////////////////
			// r-type by funct
			////////////////////
			mips_pkg::ALUOP_FUNCT: begin
				case (funct)
					// overflow trap not modelled
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU: alu_ctrl = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB, mips_pkg::FN_SUBU: alu_ctrl = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  alu_ctrl = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   alu_ctrl = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  alu_ctrl = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR:  alu_ctrl = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT:  alu_ctrl = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: alu_ctrl = mips_pkg::ALU_SLTU;
					// shamt and register shifts share the shifter
					mips_pkg::FN_SLL, mips_pkg::FN_SLLV: alu_ctrl = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL, mips_pkg::FN_SRLV: alu_ctrl = mips_pkg::ALU_SRL;
					mips_pkg::FN_SRA, mips_pkg::FN_SRAV: alu_ctrl = mips_pkg::ALU_SRA;
					// jumps, hi/lo, mul/div, traps
					default: alu_ctrl = mips_pkg::ALU_NONE;
				endcase
			end
			default: alu_ctrl = mips_pkg::ALU_NONE;
		endcase
	end
endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module decode_stage (
	input wire                  clk,
	input wire                  reset,
	input wire                  stall,
	fetch_if.reader             in_if,
	output logic                out_valid,
	output logic [`INSTR_W-1:0] out_pc,
	output logic [`INSTR_W-1:0] out_target,
	output mips_pkg::ctrl_t     out_ctrl
);
	mips_pkg::opcode_e   op;
	mips_pkg::funct_e    funct;
	mips_pkg::regimm_e   rt;
	mips_pkg::alu_op_e   alu_op;
	mips_pkg::ctrl_t     ctrl_next;
	logic [`INSTR_W-1:0] target_next;
	logic                pop;

	// field split of the fifo head
	assign op    = mips_pkg::opcode_e'(in_if.pkt.instr[31:26]);
	assign funct = mips_pkg::funct_e'(in_if.pkt.instr[5:0]);
	assign rt    = mips_pkg::regimm_e'(in_if.pkt.instr[20:16]);

	// head consumed unless stalled
	assign pop        = in_if.valid & ~stall;
	assign in_if.room = pop;

	main_decoder u_main_dec (
		.op(op), .funct(funct), .rs(in_if.pkt.instr[25:21]), .rt(rt),
		.regwrite(ctrl_next.regwrite), .regdst(ctrl_next.regdst),
		.alusrc(ctrl_next.alusrc), .branch(ctrl_next.branch),
		.memwrite(ctrl_next.memwrite), .memtoreg(ctrl_next.memtoreg),
		.jump(ctrl_next.jump), .invalid(ctrl_next.invalid), .alu_op(alu_op)
	);

	alu_decoder u_alu_dec (.alu_op(alu_op), .funct(funct), .alu_ctrl(ctrl_next.alu_ctrl));

	// register jumps have no static target
	assign target_next = (op == mips_pkg::OP_J || op == mips_pkg::OP_JAL) ?
		in_if.pkt.jump_target : (ctrl_next.branch ? in_if.pkt.branch_target : '0);

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= pop;
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			out_pc     <= in_if.pkt.pc;
			out_target <= target_next;
			out_ctrl   <= ctrl_next;
		end
	end
endmodule

`default_nettype wire

/* source/fetch_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one tagged instruction per cycle between pipeline blocks
interface fetch_if;
	// writer side
	logic                 valid;
	mips_pkg::fetch_pkt_t pkt;
	// reader side, room to accept (or pop request on fifo output)
	logic                 room;

	modport writer (
		output valid, pkt,
		input  room
	);

	modport reader (
		input  valid, pkt,
		output room
	);
endinterface

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module fetch_unit (
	input wire                clk,
	input wire                reset,
	input wire [`INSTR_W-1:0] instr_in,
	input wire                instr_strobe,
	fetch_if.writer           out_if
);
	logic [`INSTR_W-1:0] pc;
	logic [`INSTR_W-1:0] pc_plus4;
	logic [`INSTR_W-1:0] br_offset;
	logic                accept;

	// strobe dropped when downstream has no room
	assign accept = instr_strobe & out_if.room;

	assign pc_plus4 = pc + 32'd4;
	// sign-extended word offset
	assign br_offset = {{14{instr_in[15]}}, instr_in[15:0], 2'b00};

	////////////////////
	// pc and valid pulse
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			pc           <= `RESET_PC;
			out_if.valid <= 1'b0;
		end else begin
			out_if.valid <= accept;
			if (accept)
				pc <= pc_plus4;
		end
	end

	// packet payload, loaded with the accepted word
	always_ff @(posedge clk) begin
		if (accept) begin
			out_if.pkt.pc            <= pc;
			out_if.pkt.instr         <= instr_in;
			out_if.pkt.branch_target <= pc_plus4 + br_offset;
			// region of the delay slot plus index
			out_if.pkt.jump_target   <= {pc_plus4[31:28], instr_in[25:0], 2'b00};
		end
	end
endmodule

`default_nettype wire

/* source/instr_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module instr_fifo (
	input wire      clk,
	input wire      reset,
	fetch_if.reader in_if,
	fetch_if.writer out_if
);
	mips_pkg::fetch_pkt_t     mem [`FIFO_DEPTH];
	logic [`FIFO_PTR_W-1:0]   wr_ptr;
	logic [`FIFO_PTR_W-1:0]   rd_ptr;
	logic [`FIFO_PTR_W:0]     count;
	logic [`FIFO_PTR_W+1:0]   level;
	logic                     push;
	logic                     pop;

	// wrap for any depth, not only powers of two
	function automatic logic [`FIFO_PTR_W-1:0] ptr_inc(input logic [`FIFO_PTR_W-1:0] ptr);
		if (ptr == `FIFO_PTR_W'(`FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign push = in_if.valid;
	assign pop  = out_if.room;

	// stored entries plus the packet already on its way in
	assign level      = {1'b0, count} + {{(`FIFO_PTR_W + 1){1'b0}}, in_if.valid};
	assign in_if.room = level < (`FIFO_PTR_W + 2)'(`FIFO_DEPTH);

	// show-ahead head
	assign out_if.valid = count != '0;
	assign out_if.pkt   = mem[rd_ptr];

	////////////////////
	// pointers and count
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_if.pkt;
	end
endmodule

`default_nettype wire

/* source/main_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module main_decoder (
	input var mips_pkg::opcode_e op,
	input var mips_pkg::funct_e  funct,
	input wire [4:0]             rs,
	input var mips_pkg::regimm_e rt,
	output logic                 regwrite,
	output logic                 regdst,
	output logic                 alusrc,
	output logic                 branch,
	output logic                 memwrite,
	output logic                 memtoreg,
	output logic                 jump,
	output logic                 invalid,
	output mips_pkg::alu_op_e    alu_op
);
	// cop0 sub-ops in rs
	localparam logic [4:0] RS_MFC0 = 5'b00000;
	localparam logic [4:0] RS_MTC0 = 5'b00100;
	localparam logic [4:0] RS_ERET = 5'b10000;

	// {regwrite, regdst, alusrc, branch, memwrite, memtoreg}
	logic [5:0] main_sig;

	assign {regwrite, regdst, alusrc, branch, memwrite, memtoreg} = main_sig;

	always_comb begin
		main_sig = 6'b000000;
		jump     = 1'b0;
		invalid  = 1'b0;
		alu_op   = mips_pkg::ALUOP_NONE;
		case (op)
			////////////////////
			// r-type
			////////////////////
			mips_pkg::OP_SPECIAL: begin
				alu_op = mips_pkg::ALUOP_FUNCT;
				case (funct)
					mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
					mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA,
					mips_pkg::FN_SLLV, mips_pkg::FN_SRLV, mips_pkg::FN_SRAV,
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_SUBU,
					mips_pkg::FN_SLT, mips_pkg::FN_SLTU,
					mips_pkg::FN_MULT, mips_pkg::FN_MULTU, mips_pkg::FN_DIV, mips_pkg::FN_DIVU,
					mips_pkg::FN_MFHI, mips_pkg::FN_MFLO:
						main_sig = 6'b110000;
					// no gpr write
					mips_pkg::FN_MTHI, mips_pkg::FN_MTLO, mips_pkg::FN_SYSCALL, mips_pkg::FN_BREAK:
						main_sig = 6'b000000;
					mips_pkg::FN_JR:
						jump = 1'b1;
					// link into rd
					mips_pkg::FN_JALR: begin
						main_sig = 6'b110000;
						jump     = 1'b1;
					end
					default: begin
						invalid = 1'b1;
						alu_op  = mips_pkg::ALUOP_NONE;
					end
				endcase
			end
			// immediates
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: begin
				main_sig = 6'b101000;
				alu_op   = mips_pkg::ALUOP_ADD;
			end
			mips_pkg::OP_SLTI:  begin main_sig = 6'b101000; alu_op = mips_pkg::ALUOP_SLT;  end
			mips_pkg::OP_SLTIU: begin main_sig = 6'b101000; alu_op = mips_pkg::ALUOP_SLTU; end
			mips_pkg::OP_ANDI:  begin main_sig = 6'b101000; alu_op = mips_pkg::ALUOP_AND;  end
			mips_pkg::OP_ORI:   begin main_sig = 6'b101000; alu_op = mips_pkg::ALUOP_OR;   end
			mips_pkg::OP_XORI:  begin main_sig = 6'b101000; alu_op = mips_pkg::ALUOP_XOR;  end
			mips_pkg::OP_LUI:   begin main_sig = 6'b101000; alu_op = mips_pkg::ALUOP_LUI;  end
			// compare-and-branch
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ: begin
				main_sig = 6'b000100;
				alu_op   = mips_pkg::ALUOP_SUB;
			end
			mips_pkg::OP_REGIMM: begin
				alu_op = mips_pkg::ALUOP_SUB;
				case (rt)
					mips_pkg::RI_BLTZ, mips_pkg::RI_BGEZ:     main_sig = 6'b000100;
					// link variants write r31
					mips_pkg::RI_BLTZAL, mips_pkg::RI_BGEZAL: main_sig = 6'b100100;
					default: begin
						invalid = 1'b1;
						alu_op  = mips_pkg::ALUOP_NONE;
					end
				endcase
			end
			mips_pkg::OP_J:   jump = 1'b1;
			mips_pkg::OP_JAL: begin
				main_sig = 6'b100000;
				jump     = 1'b1;
			end
			// memory, address is base plus offset
			mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
			mips_pkg::OP_LBU, mips_pkg::OP_LHU: begin
				main_sig = 6'b101001;
				alu_op   = mips_pkg::ALUOP_ADD;
			end
			mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: begin
				main_sig = 6'b001010;
				alu_op   = mips_pkg::ALUOP_ADD;
			end
			// privileged, cp0 itself not modelled
			mips_pkg::OP_COP0: begin
				case (rs)
					RS_MFC0: main_sig = 6'b100000;
					RS_MTC0, RS_ERET: main_sig = 6'b000000;
					default: invalid = 1'b1;
				endcase
			end
			default: invalid = 1'b1;
		endcase
	end
endmodule

`default_nettype wire

/* source/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// instruction and address width
`define INSTR_W 32

// boot vector, first fetch after reset
`define RESET_PC 32'hbfc00000

// instruction fifo size
// depth of 2 or more, pointer wide enough for depth-1
`define FIFO_DEPTH 4
`define FIFO_PTR_W 2

`endif

/* source/mips_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module mips_decode_top (
	input wire                  clk,
	input wire                  reset,
	// instruction input
	input wire [`INSTR_W-1:0]   instr_in,
	input wire                  instr_strobe,
	input wire                  stall,
	output logic                full,
	// decoded output
	output logic                out_valid,
	output logic [`INSTR_W-1:0] out_pc,
	output logic [`INSTR_W-1:0] out_target,
	output logic                regwrite,
	output logic                regdst,
	output logic                alusrc,
	output logic                branch,
	output logic                memwrite,
	output logic                memtoreg,
	output logic                jump,
	output logic                invalid,
	output logic [3:0]          alu_ctrl
);
	mips_pkg::ctrl_t out_ctrl;

	fetch_if fetch_to_fifo ();
	fetch_if fifo_to_dec ();

	////////////////////
	// pipeline
	////////////////////
	fetch_unit u_fetch (
		.clk(clk), .reset(reset), .instr_in(instr_in), .instr_strobe(instr_strobe),
		.out_if(fetch_to_fifo.writer)
	);

	instr_fifo u_fifo (
		.clk(clk), .reset(reset), .in_if(fetch_to_fifo.reader), .out_if(fifo_to_dec.writer)
	);

	decode_stage u_decode (
		.clk(clk), .reset(reset), .stall(stall), .in_if(fifo_to_dec.reader),
		.out_valid(out_valid), .out_pc(out_pc), .out_target(out_target), .out_ctrl(out_ctrl)
	);

	// no room means the fifo can take nothing more
	assign full = ~fetch_to_fifo.room;

	// control word onto flat ports
	assign regwrite = out_ctrl.regwrite;
	assign regdst   = out_ctrl.regdst;
	assign alusrc   = out_ctrl.alusrc;
	assign branch   = out_ctrl.branch;
	assign memwrite = out_ctrl.memwrite;
	assign memtoreg = out_ctrl.memtoreg;
	assign jump     = out_ctrl.jump;
	assign invalid  = out_ctrl.invalid;
	assign alu_ctrl = out_ctrl.alu_ctrl;
endmodule

`default_nettype wire

/* source/mips_pkg.sv */
`default_nettype none

`include "mips_consts.svh"

package mips_pkg;

	////////////////////
	// encodings
	////////////////////

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
		OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
		OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
		OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
		OP_COP0    = 6'h10,
		OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
		OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
	} opcode_e;

	// function field of SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL   = 6'h00, FN_SRL   = 6'h02, FN_SRA     = 6'h03, FN_SLLV  = 6'h04,
		FN_SRLV  = 6'h06, FN_SRAV  = 6'h07, FN_JR      = 6'h08, FN_JALR  = 6'h09,
		FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d,
		FN_MFHI  = 6'h10, FN_MTHI  = 6'h11, FN_MFLO    = 6'h12, FN_MTLO  = 6'h13,
		FN_MULT  = 6'h18, FN_MULTU = 6'h19, FN_DIV     = 6'h1a, FN_DIVU  = 6'h1b,
		FN_ADD   = 6'h20, FN_ADDU  = 6'h21, FN_SUB     = 6'h22, FN_SUBU  = 6'h23,
		FN_AND   = 6'h24, FN_OR    = 6'h25, FN_XOR     = 6'h26, FN_NOR   = 6'h27,
		FN_SLT   = 6'h2a, FN_SLTU  = 6'h2b
	} funct_e;

	// rt field of REGIMM branches
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'h00,
		RI_BGEZ   = 5'h01,
		RI_BLTZAL = 5'h10,
		RI_BGEZAL = 5'h11
	} regimm_e;

	// alu class out of the main decoder
	typedef enum logic [3:0] {
		ALUOP_ADD, ALUOP_SUB, ALUOP_FUNCT, ALUOP_AND, ALUOP_OR,
		ALUOP_XOR, ALUOP_SLT, ALUOP_SLTU, ALUOP_LUI, ALUOP_NONE
	} alu_op_e;

	// resolved alu operation
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_NONE
	} alu_ctrl_e;

	////////////////////
	// bundles
	////////////////////

	// tagged instruction from fetch
	typedef struct packed {
		logic [`INSTR_W-1:0] pc;
		logic [`INSTR_W-1:0] instr;
		logic [`INSTR_W-1:0] branch_target;
		logic [`INSTR_W-1:0] jump_target;
	} fetch_pkt_t;

	// decoded control word
	typedef struct packed {
		logic      regwrite;
		logic      regdst;
		logic      alusrc;
		logic      branch;
		logic      memwrite;
		logic      memtoreg;
		logic      jump;
		logic      invalid;
		alu_ctrl_e alu_ctrl;
	} ctrl_t;

endpackage

`default_nettype wire

/* tb/tb_mips_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module tb_mips_decode;
	localparam int WAIT_LIMIT = 50;

	// one expected decode result, in strobe order
	typedef struct packed {
		logic [31:0]     instr;
		logic [31:0]     pc;
		logic [31:0]     target;
		mips_pkg::ctrl_t ctrl;
		logic            timed;
		int              due;
	} exp_t;

	// every SPECIAL funct the decoder knows
	localparam logic [5:0] FUNCTS [28] = '{
		6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0c, 6'h0d,
		6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b,
		6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
	};
	// immediate, load and store opcodes
	localparam logic [5:0] IMM_OPS [16] = '{
		6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
		6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b
	};

	logic        clk;
	logic        reset;
	logic [31:0] instr_in;
	logic        instr_strobe;
	logic        stall;
	logic        full;
	logic        out_valid;
	logic [31:0] out_pc;
	logic [31:0] out_target;
	logic        regwrite;
	logic        regdst;
	logic        alusrc;
	logic        branch;
	logic        memwrite;
	logic        memtoreg;
	logic        jump;
	logic        invalid;
	logic [3:0]  alu_ctrl;

	int          cycle;
	int          err_value;
	int          err_other;
	logic [31:0] exp_pc;
	exp_t        exp_q [$];

	mips_decode_top dut0 (.*);

	always #50 clk = ~clk;

	// edge count, used for latency
	always @(posedge clk) cycle <= cycle + 1;

	////////////////////
	// stimulus helpers
	////////////////////
	function automatic logic [4:0] rnd5();
		logic [31:0] r;
		r = $urandom();
		return r[4:0];
	endfunction

	function automatic logic [15:0] rnd16();
		logic [31:0] r;
		r = $urandom();
		return r[15:0];
	endfunction

	function automatic logic [25:0] rnd26();
		logic [31:0] r;
		r = $urandom();
		return r[25:0];
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
		return {op, idx};
	endfunction

	////////////////////
	// reference model
	////////////////////
	// flags are {regwrite, regdst, alusrc, branch, memwrite, memtoreg, jump}
	function automatic mips_pkg::ctrl_t mk(input logic [6:0] f, input mips_pkg::alu_ctrl_e a);
		mips_pkg::ctrl_t c;
		{c.regwrite, c.regdst, c.alusrc, c.branch, c.memwrite, c.memtoreg, c.jump} = f;
		c.invalid  = 1'b0;
		c.alu_ctrl = a;
		return c;
	endfunction

	// reserved encoding, only the invalid flag
	function automatic mips_pkg::ctrl_t bad();
		mips_pkg::ctrl_t c;
		c          = '0;
		c.invalid  = 1'b1;
		c.alu_ctrl = mips_pkg::ALU_NONE;
		return c;
	endfunction

	function automatic mips_pkg::ctrl_t model_ctrl(input logic [31:0] w);
		mips_pkg::ctrl_t c;
		case (w[31:26])
			6'h00:
				case (w[5:0])
					6'h20, 6'h21: c = mk(7'b1100000, mips_pkg::ALU_ADD);
					6'h22, 6'h23: c = mk(7'b1100000, mips_pkg::ALU_SUB);
					6'h24: c = mk(7'b1100000, mips_pkg::ALU_AND);
					6'h25: c = mk(7'b1100000, mips_pkg::ALU_OR);
					6'h26: c = mk(7'b1100000, mips_pkg::ALU_XOR);
					6'h27: c = mk(7'b1100000, mips_pkg::ALU_NOR);
					6'h2a: c = mk(7'b1100000, mips_pkg::ALU_SLT);
					6'h2b: c = mk(7'b1100000, mips_pkg::ALU_SLTU);
					6'h00, 6'h04: c = mk(7'b1100000, mips_pkg::ALU_SLL);
					6'h02, 6'h06: c = mk(7'b1100000, mips_pkg::ALU_SRL);
					6'h03, 6'h07: c = mk(7'b1100000, mips_pkg::ALU_SRA);
					// hi/lo reads, mul and div go down the R path
					6'h10, 6'h12, 6'h18, 6'h19, 6'h1a, 6'h1b:
						c = mk(7'b1100000, mips_pkg::ALU_NONE);
					6'h11, 6'h13, 6'h0c, 6'h0d: c = mk(7'b0000000, mips_pkg::ALU_NONE);
					6'h08: c = mk(7'b0000001, mips_pkg::ALU_NONE);
					6'h09: c = mk(7'b1100001, mips_pkg::ALU_NONE);
					default: c = bad();
				endcase
			6'h08, 6'h09: c = mk(7'b1010000, mips_pkg::ALU_ADD);
			6'h0a: c = mk(7'b1010000, mips_pkg::ALU_SLT);
			6'h0b: c = mk(7'b1010000, mips_pkg::ALU_SLTU);
			6'h0c: c = mk(7'b1010000, mips_pkg::ALU_AND);
			6'h0d: c = mk(7'b1010000, mips_pkg::ALU_OR);
			6'h0e: c = mk(7'b1010000, mips_pkg::ALU_XOR);
			6'h0f: c = mk(7'b1010000, mips_pkg::ALU_LUI);
			6'h04, 6'h05, 6'h06, 6'h07: c = mk(7'b0001000, mips_pkg::ALU_SUB);
			// regimm, link forms also write
			6'h01:
				case (w[20:16])
					5'h00, 5'h01: c = mk(7'b0001000, mips_pkg::ALU_SUB);
					5'h10, 5'h11: c = mk(7'b1001000, mips_pkg::ALU_SUB);
					default: c = bad();
				endcase
			6'h02: c = mk(7'b0000001, mips_pkg::ALU_NONE);
			6'h03: c = mk(7'b1000001, mips_pkg::ALU_NONE);
			6'h20, 6'h21, 6'h23, 6'h24, 6'h25: c = mk(7'b1010010, mips_pkg::ALU_ADD);
			6'h28, 6'h29, 6'h2b: c = mk(7'b0010100, mips_pkg::ALU_ADD);
			// cop0 by rs: mfc0, mtc0, eret
			6'h10:
				case (w[25:21])
					5'h00: c = mk(7'b1000000, mips_pkg::ALU_NONE);
					5'h04, 5'h10: c = mk(7'b0000000, mips_pkg::ALU_NONE);
					default: c = bad();
				endcase
			default: c = bad();
		endcase
		return c;
	endfunction

	// j/jal region target, branch offset from the delay slot, else zero
	function automatic logic [31:0] model_target(input logic [31:0] w, input logic [31:0] pc,
			input logic br);
		logic [31:0] next_pc;
		next_pc = pc + 32'd4;
		if (w[31:26] == 6'h02 || w[31:26] == 6'h03)
			return {next_pc[31:28], w[25:0], 2'b00};
		if (br)
			return next_pc + (32'($signed(w[15:0])) << 2);
		return 32'h0;
	endfunction

	////////////////////
	// compare tasks
	////////////////////
	task automatic check_ctrl(input mips_pkg::ctrl_t got, input mips_pkg::ctrl_t exp,
			input string msg);
		logic [7:0] gf;
		logic [7:0] ef;
		gf = {got.regwrite, got.regdst, got.alusrc, got.branch,
			got.memwrite, got.memtoreg, got.jump, got.invalid};
		ef = {exp.regwrite, exp.regdst, exp.alusrc, exp.branch,
			exp.memwrite, exp.memtoreg, exp.jump, exp.invalid};
		if (gf !== ef) begin
			$display("FAILED %0t: %s flags rw,rd,as,br,mw,mt,j,inv got %b expected %b",
				$time, msg, gf, ef);
			err_value++;
		end
	endtask

	task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("FAILED %0t: %s got %h expected %h", $time, msg, got, exp);
			err_value++;
		end
	endtask

	task automatic check_alu(input mips_pkg::alu_ctrl_e got, input mips_pkg::alu_ctrl_e exp,
			input string msg);
		if (got !== exp) begin
			$display("FAILED %0t: %s alu_ctrl got %s expected %s", $time, msg, got.name(),
				exp.name());
			err_value++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string msg);
		if (got != exp) begin
			$display("FAILED %0t: %s got %0d expected %0d", $time, msg, got, exp);
			err_value++;
		end
	endtask

	// monitor, outputs are settled at the falling edge
	always @(negedge clk) begin
		exp_t            e;
		mips_pkg::ctrl_t got;
		string           tag;
		if (!reset && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected out_valid at %0t with pc %h", $time, out_pc);
				err_other++;
			end else begin
				e   = exp_q.pop_front();
				tag = $sformatf("pc %h instr %h", e.pc, e.instr);
				got = {regwrite, regdst, alusrc, branch, memwrite, memtoreg, jump, invalid,
					alu_ctrl};
				check_addr(out_pc, e.pc, {tag, " out_pc"});
				check_addr(out_target, e.target, {tag, " out_target"});
				check_ctrl(got, e.ctrl, tag);
				check_alu(mips_pkg::alu_ctrl_e'(alu_ctrl), e.ctrl.alu_ctrl, tag);
				if (e.timed)
					check_count(cycle, e.due, {tag, " output cycle"});
			end
		end
	end

	////////////////////
	// drive tasks
	////////////////////
	// expected result of a strobe that will be accepted
	task automatic expect_instr(input logic [31:0] w, input logic timed);
		exp_t e;
		e.instr  = w;
		e.pc     = exp_pc;
		e.ctrl   = model_ctrl(w);
		e.target = model_target(w, exp_pc, e.ctrl.branch);
		e.timed  = timed;
		e.due    = cycle + 3;
		exp_q.push_back(e);
		exp_pc = exp_pc + 32'd4;
	endtask

	task automatic strobe_once(input logic [31:0] w);
		instr_in     = w;
		instr_strobe = 1'b1;
		@(negedge clk);
		instr_strobe = 1'b0;
	endtask

	task automatic send(input logic [31:0] w, input logic timed);
		int waited;
		waited = 0;
		while (full && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (full) begin
			$display("timeout at %0t: fifo stayed full, %h was not sent", $time, w);
			err_other++;
		end else begin
			expect_instr(w, timed);
			strobe_once(w);
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout at %0t: %0d instructions never came out", $time, exp_q.size());
			err_other++;
			exp_q.delete();
		end
		// quiet tail, a late pulse shows up as unexpected
		repeat (4) @(negedge clk);
	endtask

	////////////////////
	// tests
	////////////////////
	task automatic test_control_table();
		send(enc_r(rnd5(), rnd5(), rnd5(), 5'd0, 6'h20), 1'b0);
		send(enc_i(6'h08, rnd5(), rnd5(), rnd16()), 1'b0);
		send(enc_i(6'h23, rnd5(), rnd5(), rnd16()), 1'b0);
		send(enc_i(6'h2b, rnd5(), rnd5(), rnd16()), 1'b0);
		// beq, bne, blez, bgtz
		send(enc_i(6'h04, rnd5(), rnd5(), rnd16()), 1'b0);
		send(enc_i(6'h05, rnd5(), rnd5(), rnd16()), 1'b0);
		send(enc_i(6'h06, rnd5(), 5'd0, rnd16()), 1'b0);
		send(enc_i(6'h07, rnd5(), 5'd0, rnd16()), 1'b0);
		// bltz, bgez, bltzal, bgezal
		send(enc_i(6'h01, rnd5(), 5'h00, rnd16()), 1'b0);
		send(enc_i(6'h01, rnd5(), 5'h01, rnd16()), 1'b0);
		send(enc_i(6'h01, rnd5(), 5'h10, rnd16()), 1'b0);
		send(enc_i(6'h01, rnd5(), 5'h11, rnd16()), 1'b0);
		// j, jal, jr, jalr
		send(enc_j(6'h02, rnd26()), 1'b0);
		send(enc_j(6'h03, rnd26()), 1'b0);
		send(enc_r(rnd5(), 5'd0, 5'd0, 5'd0, 6'h08), 1'b0);
		send(enc_r(rnd5(), 5'd0, 5'd31, 5'd0, 6'h09), 1'b0);
		// mfc0, mtc0, eret
		send({6'h10, 5'h00, rnd5(), rnd5(), 11'h000}, 1'b0);
		send({6'h10, 5'h04, rnd5(), rnd5(), 11'h000}, 1'b0);
		send(32'h42000018, 1'b0);
		drain();
	endtask

	task automatic test_alu_control();
		for (int i = 0; i < 28; i++)
			send(enc_r(rnd5(), rnd5(), rnd5(), rnd5(), FUNCTS[i]), 1'b0);
		for (int i = 0; i < 16; i++)
			send(enc_i(IMM_OPS[i], rnd5(), rnd5(), rnd16()), 1'b0);
		drain();
	endtask

	task automatic test_addresses();
		// forward, backward and extreme offsets
		send(enc_i(6'h04, rnd5(), rnd5(), 16'h0010), 1'b0);
		send(enc_i(6'h05, rnd5(), rnd5(), 16'hfff0), 1'b0);
		send(enc_i(6'h07, rnd5(), 5'd0, 16'h7fff), 1'b0);
		send(enc_i(6'h01, rnd5(), 5'h11, 16'h8000), 1'b0);
		for (int i = 0; i < 4; i++)
			send(enc_i(6'h06, rnd5(), 5'd0, rnd16()), 1'b0);
		for (int i = 0; i < 4; i++)
			send(enc_j((i % 2 == 0) ? 6'h02 : 6'h03, rnd26()), 1'b0);
		// no static target
		send(enc_r(rnd5(), rnd5(), rnd5(), 5'd0, 6'h21), 1'b0);
		send(enc_i(6'h23, rnd5(), rnd5(), rnd16()), 1'b0);
		send(enc_r(rnd5(), 5'd0, 5'd0, 5'd0, 6'h08), 1'b0);
		drain();
	endtask

	task automatic test_invalid();
		send(enc_i(6'h3f, rnd5(), rnd5(), rnd16()), 1'b0);
		send(enc_i(6'h11, rnd5(), rnd5(), rnd16()), 1'b0);
		send(enc_r(rnd5(), rnd5(), rnd5(), 5'd0, 6'h01), 1'b0);
		send(enc_r(rnd5(), rnd5(), rnd5(), 5'd0, 6'h3f), 1'b0);
		send(enc_i(6'h01, rnd5(), 5'h02, rnd16()), 1'b0);
		send({6'h10, 5'h01, rnd5(), rnd5(), 11'h000}, 1'b0);
		drain();
	endtask

	task automatic test_latency();
		send(enc_r(rnd5(), rnd5(), rnd5(), 5'd0, 6'h21), 1'b1);
		drain();
		// back to back, one out per cycle
		for (int i = 0; i < 5; i++)
			send(enc_i(6'h09, rnd5(), rnd5(), rnd16()), 1'b1);
		drain();
	endtask

	task automatic test_backpressure();
		int          accepted;
		int          dropped;
		int          n;
		logic [31:0] w;
		accepted = 0;
		dropped  = 0;
		n        = 0;
		stall    = 1'b1;
		while (dropped < 3 && n < WAIT_LIMIT) begin
			w = enc_i(6'h09, rnd5(), rnd5(), rnd16());
			if (out_valid) begin
				$display("out_valid went high at %0t while stalled", $time);
				err_other++;
			end
			// full during this cycle means the strobe is dropped
			if (full) begin
				if (dropped == 0)
					check_count(accepted, `FIFO_DEPTH, "strobes accepted before full");
				dropped++;
			end else begin
				accepted++;
				expect_instr(w, 1'b0);
			end
			strobe_once(w);
			n++;
		end
		if (dropped < 3) begin
			$display("timeout at %0t: full never rose under stall", $time);
			err_other++;
		end
		stall = 1'b0;
		drain();
	endtask

	initial begin
		void'($urandom(32'ha599));
		clk          = 1'b0;
		reset        = 1'b1;
		instr_in     = 32'h0;
		instr_strobe = 1'b0;
		stall        = 1'b0;
		cycle        = 0;
		err_value    = 0;
		err_other    = 0;
		exp_pc       = `RESET_PC;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		// idle out of reset
		check_count(int'(full), 0, "full after reset");
		check_count(int'(out_valid), 0, "out_valid after reset");
		test_control_table();
		test_alu_control();
		test_addresses();
		test_invalid();
		test_latency();
		test_backpressure();
		$display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
		if (err_value + err_other == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end
endmodule

`default_nettype wire
